/* files.f */
dds_pkg.sv
burst_timer_if.sv
burst_timer.sv
burst_fsm.sv
phase_accumulator.sv
wave_shaper.sv
dds_top.sv
dds_checker.sv
tb_dds_top.sv

/* Bender.yml */
package:
  name: dds_burst_tone

sources:
  - dds_pkg.sv
  - burst_timer_if.sv
  - burst_timer.sv
  - burst_fsm.sv
  - phase_accumulator.sv
  - wave_shaper.sv
  - dds_top.sv
  - target: test
    files:
      - dds_checker.sv
      - tb_dds_top.sv

/* tb_dds_top.sv */
// Testbench top for the burst-gated DDS generator; runs seeded random bursts and reports the result
`timescale 1ns/1ps

module tb_dds_top;
    import dds_pkg::*;

    localparam int num_phases = 24;

    logic                   clk;
    logic                   reset;
    logic                   start;
    logic                   stop;
    logic                   repeat_mode;
    logic [len_width-1:0]   burst_len;
    logic [len_width-1:0]   gap_len;
    logic [phase_width-1:0] freq_word;
    wave_t                  wave_sel;
    logic [out_width-1:0]   wave_out;
    logic                   busy;
    int                     error_count;
    int                     sample_count;
    int                     cycle_count = 0;
    int                     cycle_limit = 0;

    // Per-phase schedule with kind 0 single burst, 1 repeat run, 2 stopped burst
    int phase_kind [num_phases];
    int phase_burst [num_phases];
    int phase_gap [num_phases];
    int phase_hold [num_phases];

    dds_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .stop        (stop),
        .repeat_mode (repeat_mode),
        .burst_len   (burst_len),
        .gap_len     (gap_len),
        .freq_word   (freq_word),
        .wave_sel    (wave_sel),
        .wave_out    (wave_out),
        .busy        (busy)
    );

    dds_checker u_checker (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .stop         (stop),
        .repeat_mode  (repeat_mode),
        .burst_len    (burst_len),
        .gap_len      (gap_len),
        .freq_word    (freq_word),
        .wave_sel     (wave_sel),
        .wave_out     (wave_out),
        .busy         (busy),
        .error_count  (error_count),
        .sample_count (sample_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Pulse tasks are called right after a rising edge
    task automatic pulse_start();
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic pulse_stop();
        stop <= 1'b1;
        @(posedge clk);
        stop <= 1'b0;
    endtask

    task automatic wait_until_idle();
        @(posedge clk);
        while (busy) @(posedge clk);
    endtask

    // New frequency word and waveform with a bias toward large words that wrap often
    task automatic set_tone();
        if ($urandom % 4 == 0) begin
            freq_word <= phase_width'(12'hf00 + $urandom % 256);
        end else begin
            freq_word <= phase_width'($urandom % 4096);
        end
        wave_sel <= wave_t'($urandom % 4);
    endtask

    task automatic run_single(input int idx);
        burst_len   <= len_width'(phase_burst[idx]);
        repeat_mode <= 1'b0;
        set_tone();
        pulse_start();
        if (phase_burst[idx] > 2) begin
            // Retune mid-burst and send a start that must be ignored
            wait_cycles(1 + $urandom % (phase_burst[idx] - 2));
            set_tone();
            pulse_start();
        end
        wait_until_idle();
        wait_cycles(1 + $urandom % 4);
    endtask

    task automatic run_repeat(input int idx);
        burst_len   <= len_width'(phase_burst[idx]);
        gap_len     <= len_width'(phase_gap[idx]);
        repeat_mode <= 1'b1;
        set_tone();
        pulse_start();
        wait_cycles(phase_hold[idx] / 2);
        set_tone();
        wait_cycles(phase_hold[idx] - phase_hold[idx] / 2);
        if ($urandom % 2 == 0) begin
            pulse_stop();
        end else begin
            repeat_mode <= 1'b0;
        end
        wait_until_idle();
        repeat_mode <= 1'b0;
        wait_cycles(1 + $urandom % 4);
    endtask

    task automatic run_stopped(input int idx);
        burst_len   <= len_width'(phase_burst[idx]);
        gap_len     <= len_width'(phase_gap[idx]);
        repeat_mode <= 1'($urandom % 2);
        set_tone();
        pulse_start();
        wait_cycles(phase_hold[idx]);
        pulse_stop();
        wait_until_idle();
        repeat_mode <= 1'b0;
        wait_cycles(1 + $urandom % 4);
    endtask

    initial begin
        int total;
        reset       = 1'b1;
        start       = 1'b0;
        stop        = 1'b0;
        repeat_mode = 1'b0;
        burst_len   = '0;
        gap_len     = '0;
        freq_word   = '0;
        wave_sel    = wave_sine;
        void'($urandom(32'h674a4c23));

        total = 0;
        for (int i = 0; i < num_phases; i++) begin
            phase_kind[i]  = $urandom % 3;
            phase_burst[i] = 1 + $urandom % 40;
            phase_gap[i]   = 1 + $urandom % 20;
            if (i == 1) begin
                phase_kind[i]  = 0;
                phase_burst[i] = 0;
            end
            case (phase_kind[i])
                1: phase_hold[i] = (2 + $urandom % 2) * (phase_burst[i] + phase_gap[i]);
                2: phase_hold[i] = $urandom % (phase_burst[i] + phase_gap[i] + 1);
                default: phase_hold[i] = 0;
            endcase
            total += phase_hold[i] + 2 * (phase_burst[i] + phase_gap[i]) + 12;
        end
        cycle_limit = 2 * total + 200;

        wait_cycles(5);
        reset <= 1'b0;
        wait_cycles(2);

        for (int i = 0; i < num_phases; i++) begin
            case (phase_kind[i])
                1: run_repeat(i);
                2: run_stopped(i);
                default: run_single(i);
            endcase
        end

        wait_cycles(5);
        $display("Run complete: %0d errors, %0d samples checked", error_count, sample_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* dds_checker.sv */
// Testbench checker for the DDS generator; models the burst sequence cycle by cycle and compares
`timescale 1ns/1ps

module dds_checker (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic                            stop,
    input  logic                            repeat_mode,
    input  logic [dds_pkg::len_width-1:0]   burst_len,
    input  logic [dds_pkg::len_width-1:0]   gap_len,
    input  logic [dds_pkg::phase_width-1:0] freq_word,
    input  dds_pkg::wave_t                  wave_sel,
    input  logic [dds_pkg::out_width-1:0]   wave_out,
    input  logic                            busy,
    output int                              error_count,
    output int                              sample_count
);
    import dds_pkg::*;

    // Model of the sequencer, remaining interval, phase and registered output
    burst_state_t         m_state;
    int                   m_left;
    logic [phase_width-1:0] m_phase;
    logic [out_width-1:0] m_out;

    // A zero length still lasts one cycle
    function automatic int interval_len(input logic [len_width-1:0] len);
        if (len == '0) begin
            return 1;
        end
        return int'(len);
    endfunction

    // Sample for a given phase, built from the waveform definitions
    function automatic logic [out_width-1:0] expected_shape(
        input logic [phase_width-1:0] ph,
        input wave_t                  sel
    );
        logic [out_width-1:0] ramp;
        case (sel)
            wave_sine: begin
                return sine_table[ph[11:8]];
            end
            wave_triangle: begin
                ramp = ph[10:3];
                if (ph[11]) begin
                    ramp = ~ramp;
                end
                return ramp;
            end
            wave_sawtooth: begin
                return ph[11:4];
            end
            default: begin
                return ph[11] ? 8'hff : 8'h00;
            end
        endcase
    endfunction

    initial begin
        error_count  = 0;
        sample_count = 0;
    end

    always @(posedge clk) begin : model
        logic                   gated;
        logic [phase_width-1:0] next_phase;
        logic [out_width-1:0]   next_out;
        if (reset) begin
            m_state = st_idle;
            m_left  = 0;
            m_phase = '0;
            m_out   = mid_scale;
        end else begin
            // Outputs seen here were set at the previous edge
            sample_count = sample_count + 1;
            if (wave_out !== m_out) begin
                error_count = error_count + 1;
                $display("FAIL %0t: wave_out expected %0d observed %0d", $time, m_out, wave_out);
            end
            if (busy !== (m_state != st_idle)) begin
                error_count = error_count + 1;
                $display("FAIL %0t: busy expected %0b observed %0b", $time,
                         m_state != st_idle, busy);
            end

            gated = (m_state == st_burst);
            next_out = gated ? expected_shape(m_phase, wave_sel) : mid_scale;
            // Phase wraps modulo 4096 through the 12-bit truncation
            next_phase = gated ? m_phase + freq_word : '0;

            if (stop) begin
                m_state = st_idle;
            end else if (m_state == st_idle) begin
                if (start) begin
                    m_state = st_burst;
                    m_left  = interval_len(burst_len);
                end
            end else if (m_left > 1) begin
                m_left = m_left - 1;
            end else if (m_state == st_burst) begin
                if (repeat_mode) begin
                    m_state = st_gap;
                    m_left  = interval_len(gap_len);
                end else begin
                    m_state = st_idle;
                end
            end else begin
                m_state = st_burst;
                m_left  = interval_len(burst_len);
            end

            m_phase = next_phase;
            m_out   = next_out;
        end
    end

endmodule

/* dds_top.sv */
// Top level of the burst-gated DDS tone generator; wires FSM, timer, accumulator and shaper
`timescale 1ns/1ps

module dds_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic                            stop,
    input  logic                            repeat_mode,
    input  logic [dds_pkg::len_width-1:0]   burst_len,
    input  logic [dds_pkg::len_width-1:0]   gap_len,
    input  logic [dds_pkg::phase_width-1:0] freq_word,
    input  dds_pkg::wave_t                  wave_sel,
    output logic [dds_pkg::out_width-1:0]   wave_out,
    output logic                            busy
);
    import dds_pkg::*;

    logic                   gate;
    logic [phase_width-1:0] phase;

    burst_timer_if tmr_if ();

    burst_timer u_timer (
        .clk   (clk),
        .reset (reset),
        .tmr   (tmr_if.timer)
    );

    burst_fsm u_fsm (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .stop        (stop),
        .repeat_mode (repeat_mode),
        .burst_len   (burst_len),
        .gap_len     (gap_len),
        .tmr         (tmr_if.fsm),
        .gate        (gate),
        .busy        (busy)
    );

    // Gate feeds both the accumulator and the shaper in the same cycle
    phase_accumulator u_acc (
        .clk       (clk),
        .reset     (reset),
        .gate      (gate),
        .freq_word (freq_word),
        .phase     (phase)
    );

    wave_shaper u_shaper (
        .clk      (clk),
        .reset    (reset),
        .gate     (gate),
        .phase    (phase),
        .wave_sel (wave_sel),
        .wave_out (wave_out)
    );

endmodule

/* wave_shaper.sv */
// Registered waveform shaper; turns the phase into sine, triangle, sawtooth or square samples
`timescale 1ns/1ps

module wave_shaper (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            gate,
    input  logic [dds_pkg::phase_width-1:0] phase,
    input  dds_pkg::wave_t                  wave_sel,
    output logic [dds_pkg::out_width-1:0]   wave_out
);
    import dds_pkg::*;

    logic [$clog2(sine_depth)-1:0] sine_addr;
    logic [out_width-1:0]          sine_wave;
    logic [out_width-1:0]          triangle_wave;
    logic [out_width-1:0]          sawtooth_wave;
    logic [out_width-1:0]          square_wave;
    logic [out_width-1:0]          shape;
    logic [out_width-1:0]          sample_next;

    // Top phase bits address the sine table
    assign sine_addr = phase[phase_width-1 -: $clog2(sine_depth)];
    assign sine_wave = sine_table[sine_addr];

    // Rising ramp in the first half period and mirrored in the second
    always_comb begin
        if (phase[phase_width-1]) begin
            triangle_wave = ~phase[phase_width-2 -: out_width];
        end else begin
            triangle_wave = phase[phase_width-2 -: out_width];
        end
    end

    assign sawtooth_wave = phase[phase_width-1 -: out_width];
    assign square_wave   = {out_width{phase[phase_width-1]}};

    always_comb begin
        case (wave_sel)
            wave_sine:     shape = sine_wave;
            wave_triangle: shape = triangle_wave;
            wave_sawtooth: shape = sawtooth_wave;
            wave_square:   shape = square_wave;
            default:       shape = sine_wave;
        endcase
    end

    // Park at mid-scale outside a burst
    always_comb begin
        if (gate) begin
            sample_next = shape;
        end else begin
            sample_next = mid_scale;
        end
    end

    // One cycle of latency from phase to output
    always_ff @(posedge clk) begin
        if (reset) begin
            wave_out <= mid_scale;
        end else begin
            wave_out <= sample_next;
        end
    end

endmodule

/* phase_accumulator.sv */
// DDS phase accumulator; advances by the frequency word while gated and sits at zero otherwise
`timescale 1ns/1ps

module phase_accumulator (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            gate,
    input  logic [dds_pkg::phase_width-1:0] freq_word,
    output logic [dds_pkg::phase_width-1:0] phase
);
    import dds_pkg::*;

    logic [phase_width-1:0] phase_next;

    // Natural wrap of the adder gives modulo 2**phase_width
    always_comb begin
        if (gate) begin
            phase_next = phase + freq_word;
        end else begin
            phase_next = '0;
        end
    end

    // Clearing while ungated makes every burst start at phase zero
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
        end else begin
            phase <= phase_next;
        end
    end

endmodule

/* burst_fsm.sv */
// Burst sequencer FSM; steps idle, burst and gap using the interval timer and gates the DDS core
`timescale 1ns/1ps

module burst_fsm (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  logic                          stop,
    input  logic                          repeat_mode,
    input  logic [dds_pkg::len_width-1:0] burst_len,
    input  logic [dds_pkg::len_width-1:0] gap_len,
    burst_timer_if.fsm                    tmr,
    output logic                          gate,
    output logic                          busy
);
    import dds_pkg::*;

    burst_state_t         state;
    burst_state_t         next_state;
    logic                 load;
    logic [len_width-1:0] load_value;

    always_comb begin
        next_state = state;
        load       = 1'b0;
        load_value = burst_len;

        case (state)
            st_idle: begin
                if (start) begin
                    next_state = st_burst;
                    load       = 1'b1;
                    load_value = burst_len;
                end
            end
            st_burst: begin
                if (tmr.last) begin
                    if (repeat_mode) begin
                        next_state = st_gap;
                        load       = 1'b1;
                        load_value = gap_len;
                    end else begin
                        next_state = st_idle;
                    end
                end
            end
            st_gap: begin
                if (tmr.last) begin
                    next_state = st_burst;
                    load       = 1'b1;
                    load_value = burst_len;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase

        // Stop overrides every other transition, a start in idle included
        if (stop) begin
            next_state = st_idle;
            load       = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    assign tmr.load       = load;
    assign tmr.load_value = load_value;

    assign gate = (state == st_burst);
    assign busy = (state != st_idle);

endmodule

/* burst_timer.sv */
// Loadable down-counter that flags the last cycle of a burst or gap interval for the burst FSM
`timescale 1ns/1ps

module burst_timer (
    input logic         clk,
    input logic         reset,
    burst_timer_if.timer tmr
);
    import dds_pkg::*;

    logic [len_width-1:0] count;
    logic [len_width-1:0] load_count;

    // A zero length still gives a one-cycle interval
    always_comb begin
        if (tmr.load_value == '0) begin
            load_count = len_width'(1);
        end else begin
            load_count = tmr.load_value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (tmr.load) begin
            count <= load_count;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Count of one is the final cycle, so an interval lasts load_value cycles
    assign tmr.last    = (count == len_width'(1));
    assign tmr.running = (count != '0);

endmodule

/* burst_timer_if.sv */
// Link between the burst FSM and its interval timer; instantiate once and hand out the modports
`timescale 1ns/1ps

interface burst_timer_if;
    import dds_pkg::*;

    // Load request and interval length from the FSM
    logic                 load;
    logic [len_width-1:0] load_value;

    // Timer status back to the FSM
    logic                 last;
    logic                 running;

    modport fsm (
        output load,
        output load_value,
        input  last,
        input  running
    );

    modport timer (
        input  load,
        input  load_value,
        output last,
        output running
    );

endinterface

/* dds_pkg.sv */
// Shared widths, sine table and enums for the burst-gated DDS tone generator; import where needed
package dds_pkg;

    // Phase accumulator and frequency word width
    localparam int phase_width = 12;

    // Output sample width
    localparam int out_width = 8;

    // Burst and gap lengths, and the timer count
    localparam int len_width = 16;

    // Sine table is indexed by the top four phase bits
    localparam int sine_depth = 16;

    // One full sine period in offset binary around mid-scale
    localparam logic [out_width-1:0] sine_table [sine_depth] = '{
        8'd128, 8'd176, 8'd218, 8'd245,
        8'd255, 8'd245, 8'd218, 8'd176,
        8'd128, 8'd79,  8'd37,  8'd10,
        8'd0,   8'd10,  8'd37,  8'd79
    };

    // Resting output code equals the sine table entry at phase zero
    localparam logic [out_width-1:0] mid_scale = 8'd128;

    // Waveform select opcodes
    typedef enum logic [1:0] {
        wave_sine     = 2'd0,
        wave_triangle = 2'd1,
        wave_sawtooth = 2'd2,
        wave_square   = 2'd3
    } wave_t;

    // Burst sequencing states
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_burst = 2'd1,
        st_gap   = 2'd2
    } burst_state_t;

endpackage
